/* files.f */
+incdir+hw
hw/byp_pkg.sv
hw/byp_stage_if.sv
hw/byp_match_if.sv
hw/byp_reg_match.sv
hw/byp_fwd_ctrl.sv
hw/byp_stall_ctrl.sv
hw/byp_ctrl_top.sv
test/tb_byp_checker.sv
test/tb_byp_ctrl.sv

/* test/tb_byp_ctrl.sv */
/*
 * Testbench for the operand bypass and hazard control
 * Applies a table of pipeline snapshots to the DUT, one per clock cycle
 */

`timescale 1ns/1ps
`default_nettype none

`include "byp_macros.svh"

module tb_byp_ctrl;

  localparam int clk_period   = 100;
  localparam int reset_cycles = 4;
  localparam int wait_limit   = 20;

  // Short names for the select codes in the expected column
  localparam logic [1:0] frf = byp_pkg::SEL_REGFILE;
  localparam logic [1:0] fex = byp_pkg::SEL_FW_EX;
  localparam logic [1:0] fwb = byp_pkg::SEL_FW_WB;
  localparam logic       jrf = byp_pkg::SELJ_REGFILE;
  localparam logic       jwb = byp_pkg::SELJ_FW_WB;

  // Flag groups of one snapshot, most significant field first
  typedef struct packed {
    logic valid, jalr, csr, mret, wfi, fetch_err, trigger;
  } id_t;
  typedef struct packed {
    logic valid, we, lsu, csr, mret, wfi;
  } ex_t;
  typedef struct packed {
    logic valid, we, lsu, csr, mret, ready;
  } wb_t;

  // One table row with exp_out packed as {op_a, op_b, jalr_sel, load, jalr, csr, wfi, deassert_we}
  typedef struct packed {
    logic [8*16-1:0]            name;
    logic [`BYP_NUM_RPORTS-1:0] re;
    byp_pkg::rf_addr_t          raddr_a;
    byp_pkg::rf_addr_t          raddr_b;
    id_t                        id;
    byp_pkg::rf_addr_t          ex_waddr;
    ex_t                        ex;
    byp_pkg::rf_addr_t          wb_waddr;
    wb_t                        wb;
    logic [9:0]                 exp_out;
  } vec_t;

  logic        clk = 1'b0;
  logic        rst_n_i = 1'b0;
  logic        chk_en = 1'b0;
  logic        chk_done;
  logic [31:0] err_cnt;
  logic [31:0] n_vectors = '0;
  vec_t        cur = '0;
  vec_t        vectors[$];
  wire  [9:0]  dut_out;

  always #(clk_period / 2) clk = ~clk;

  // Release lands just after an edge so the checker never sees it change mid-sample
  initial begin
    // Every input but the valid bits and the fault flags is busy during reset
    // Idle outputs then come from the valid gating alone
    cur.re       = 2'b11;
    cur.raddr_a  = 5'd1;
    cur.raddr_b  = 5'd1;
    cur.id       = 7'b0111100;
    cur.ex_waddr = 5'd1;
    cur.ex       = 6'b011111;
    cur.wb_waddr = 5'd1;
    cur.wb       = 6'b011110;
    repeat (reset_cycles) @(posedge clk);
    #1;
    rst_n_i = 1'b1;
  end

  byp_ctrl_top UUT (
    .rf_re_id_i      (cur.re),
    .rf_raddr_a_id_i (cur.raddr_a),
    .rf_raddr_b_id_i (cur.raddr_b),
    .id_valid_i      (cur.id.valid),
    .jalr_id_i       (cur.id.jalr),
    .csr_id_i        (cur.id.csr),
    .mret_id_i       (cur.id.mret),
    .wfi_id_i        (cur.id.wfi),
    .fetch_err_id_i  (cur.id.fetch_err),
    .trigger_id_i    (cur.id.trigger),
    .ex_valid_i      (cur.ex.valid),
    .ex_rf_we_i      (cur.ex.we),
    .ex_rf_waddr_i   (cur.ex_waddr),
    .ex_lsu_en_i     (cur.ex.lsu),
    .ex_csr_en_i     (cur.ex.csr),
    .ex_mret_i       (cur.ex.mret),
    .ex_wfi_i        (cur.ex.wfi),
    .wb_valid_i      (cur.wb.valid),
    .wb_rf_we_i      (cur.wb.we),
    .wb_rf_waddr_i   (cur.wb_waddr),
    .wb_lsu_en_i     (cur.wb.lsu),
    .wb_csr_en_i     (cur.wb.csr),
    .wb_mret_i       (cur.wb.mret),
    .wb_ready_i      (cur.wb.ready),
    .op_a_sel_o      (dut_out[9:8]),
    .op_b_sel_o      (dut_out[7:6]),
    .jalr_sel_o      (dut_out[5]),
    .load_stall_o    (dut_out[4]),
    .jalr_stall_o    (dut_out[3]),
    .csr_stall_o     (dut_out[2]),
    .wfi_stall_o     (dut_out[1]),
    .deassert_we_o   (dut_out[0])
  );

  tb_byp_checker u_checker (
    .clk_i     (clk),
    .rst_n_i   (rst_n_i),
    .chk_en_i  (chk_en),
    .name_i    (cur.name),
    .exp_i     (cur.exp_out),
    .out_i     (dut_out),
    .total_i   (n_vectors),
    .done_o    (chk_done),
    .err_cnt_o (err_cnt)
  );

  task automatic add_vec(input logic [8*16-1:0] name, input logic [1:0] re,
                         input byp_pkg::rf_addr_t ra, input byp_pkg::rf_addr_t rb,
                         input id_t id, input byp_pkg::rf_addr_t ex_wa, input ex_t ex,
                         input byp_pkg::rf_addr_t wb_wa, input wb_t wb,
                         input logic [9:0] exp_out);
    vectors.push_back({name, re, ra, rb, id, ex_wa, ex, wb_wa, wb, exp_out});
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Vector table
  ////////////////////////////////////////////////////////////////////////////

  // Each row lists name, re, raddr_a, raddr_b, id {v jalr csr mret wfi ferr trig}
  //             ex_waddr, ex {v we lsu csr mret wfi}, wb_waddr, wb {v we lsu csr mret rdy}
  task automatic load_vectors;
    add_vec("a_ex_b_wb",      2'b11, 5'd1,  5'd2,  7'b1000000,
            5'd1,  6'b110000, 5'd2,  6'b110001, {fex, fwb, jrf, 5'b00000});
    // EX is younger, so it wins when both stages write the register
    add_vec("both_hit_ex",    2'b11, 5'd3,  5'd3,  7'b1000000,
            5'd3,  6'b110000, 5'd3,  6'b110001, {fex, fex, jwb, 5'b00000});
    add_vec("a_wb_b_ex",      2'b11, 5'd4,  5'd5,  7'b1000000,
            5'd5,  6'b110000, 5'd4,  6'b110001, {fwb, fex, jwb, 5'b00000});
    add_vec("x0_read",        2'b11, 5'd0,  5'd0,  7'b1000000,
            5'd0,  6'b110000, 5'd0,  6'b110001, {frf, frf, jrf, 5'b00000});
    add_vec("re_low",         2'b00, 5'd6,  5'd7,  7'b1000000,
            5'd6,  6'b110000, 5'd7,  6'b110001, {frf, frf, jrf, 5'b00000});
    add_vec("we_low",         2'b11, 5'd8,  5'd8,  7'b1000000,
            5'd8,  6'b100000, 5'd8,  6'b100001, {frf, frf, jrf, 5'b00000});
    // Invalid stages carry a load and a busy WB, neither may stall
    add_vec("stage_invalid",  2'b11, 5'd9,  5'd9,  7'b1000000,
            5'd9,  6'b011000, 5'd9,  6'b010000, {frf, frf, jrf, 5'b00000});
    add_vec("load_ex_use",    2'b01, 5'd10, 5'd0,  7'b1000000,
            5'd10, 6'b111000, 5'd0,  6'b000001, {fex, frf, jrf, 5'b10000});
    add_vec("wb_busy_hit",    2'b10, 5'd0,  5'd14, 7'b1000000,
            5'd0,  6'b000000, 5'd14, 6'b110000, {frf, fwb, jrf, 5'b10000});
    add_vec("wb_ready_hit",   2'b10, 5'd0,  5'd14, 7'b1000000,
            5'd0,  6'b000000, 5'd14, 6'b110001, {frf, fwb, jrf, 5'b00000});
    // The JALR hit ignores the read enable, so re stays low here
    add_vec("jalr_ex_wr",     2'b00, 5'd15, 5'd0,  7'b1100000,
            5'd15, 6'b110000, 5'd0,  6'b000001, {frf, frf, jrf, 5'b01000});
    add_vec("jalr_wb_alu",    2'b01, 5'd16, 5'd0,  7'b1100000,
            5'd0,  6'b000000, 5'd16, 6'b110001, {fwb, frf, jwb, 5'b00000});
    add_vec("jalr_wb_load",   2'b01, 5'd16, 5'd0,  7'b1100000,
            5'd0,  6'b000000, 5'd16, 6'b111001, {fwb, frf, jwb, 5'b01000});
    add_vec("csr_ex_csr",     2'b00, 5'd0,  5'd0,  7'b1010000,
            5'd0,  6'b100100, 5'd0,  6'b000001, {frf, frf, jrf, 5'b00100});
    add_vec("mret_wb_mret",   2'b00, 5'd0,  5'd0,  7'b1001000,
            5'd0,  6'b000000, 5'd0,  6'b100011, {frf, frf, jrf, 5'b00100});
    add_vec("wfi_ex_mret",    2'b00, 5'd0,  5'd0,  7'b1000100,
            5'd0,  6'b100010, 5'd0,  6'b000001, {frf, frf, jrf, 5'b00100});
    add_vec("csr_stage_inv",  2'b00, 5'd0,  5'd0,  7'b1010000,
            5'd0,  6'b000110, 5'd0,  6'b000111, {frf, frf, jrf, 5'b00000});
    add_vec("wfi_in_ex",      2'b00, 5'd0,  5'd0,  7'b0000000,
            5'd0,  6'b100001, 5'd0,  6'b000001, {frf, frf, jrf, 5'b00010});
    add_vec("fetch_err",      2'b00, 5'd0,  5'd0,  7'b1000010,
            5'd0,  6'b000000, 5'd0,  6'b000001, {frf, frf, jrf, 5'b00001});
    add_vec("trigger",        2'b00, 5'd0,  5'd0,  7'b0000001,
            5'd0,  6'b000000, 5'd0,  6'b000001, {frf, frf, jrf, 5'b00001});
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Drive loop
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int cycles;
    load_vectors();
    n_vectors = vectors.size();
    cycles = 0;
    while (!rst_n_i && cycles < wait_limit) begin
      @(posedge clk);
      cycles++;
    end
    if (!rst_n_i) begin
      $display("Reset was not released within %0d cycles", wait_limit);
    end else begin
      #1;
      foreach (vectors[i]) begin
        cur    = vectors[i];
        chk_en = 1'b1;
        @(posedge clk);
        #1;
      end
      chk_en = 1'b0;
      cur    = '0;
      cycles = 0;
      while (!chk_done && cycles < wait_limit) begin
        @(posedge clk);
        cycles++;
      end
      if (!chk_done) begin
        $display("Checker did not finish within %0d cycles of the last vector", wait_limit);
      end
    end
    if (rst_n_i && chk_done && err_cnt == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* test/tb_byp_checker.sv */
/*
 * Testbench checker for the bypass and hazard control
 * Samples the DUT outputs on each rising edge and compares them to the table
 */

`timescale 1ns/1ps
`default_nettype none

module tb_byp_checker (
  input  wire logic            clk_i,
  input  wire logic            rst_n_i,
  input  wire logic            chk_en_i,
  input  wire logic [8*16-1:0] name_i,
  input  wire logic [9:0]      exp_i,
  input  wire logic [9:0]      out_i,
  input  wire logic [31:0]     total_i,
  output logic                 done_o,
  output logic [31:0]          err_cnt_o
);

  // During reset every select sits on the register file and no stall is raised
  localparam logic [9:0] idle_out = {byp_pkg::SEL_REGFILE, byp_pkg::SEL_REGFILE,
                                     byp_pkg::SELJ_REGFILE, 5'b00000};

  int   n_tests;
  int   n_fail;
  int   n_vec;
  logic in_reset;
  logic reset_bad;

  initial begin
    n_tests   = 0;
    n_fail    = 0;
    n_vec     = 0;
    in_reset  = 1'b0;
    reset_bad = 1'b0;
    done_o    = 1'b0;
    err_cnt_o = '0;
  end

  // Fields are op_a, op_b, jalr_sel and the five stall bits in table order
  task automatic report_mismatch(input logic [8*16-1:0] name, input logic [9:0] exp_v,
                                 input logic [9:0] act_v);
    $display("Error %0s: expected a=%0d b=%0d j=%0d stall=%b, actual a=%0d b=%0d j=%0d stall=%b",
             name, exp_v[9:8], exp_v[7:6], exp_v[5], exp_v[4:0],
             act_v[9:8], act_v[7:6], act_v[5], act_v[4:0]);
  endtask

  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      in_reset = 1'b1;
      // Only the first idle violation gets a line of its own
      if (out_i !== idle_out && !reset_bad) begin
        reset_bad = 1'b1;
        report_mismatch("reset_idle", idle_out, out_i);
      end
    end else begin
      // The reset phase counts as one test once it is over
      if (in_reset) begin
        in_reset = 1'b0;
        n_tests++;
        if (reset_bad) begin
          n_fail++;
        end else begin
          $display("ok    reset_idle");
        end
      end
      if (chk_en_i) begin
        n_tests++;
        n_vec++;
        if (out_i !== exp_i) begin
          n_fail++;
          report_mismatch(name_i, exp_i, out_i);
        end else begin
          $display("ok    %0s", name_i);
        end
        if (n_vec == total_i) begin
          $display("Checked %0d tests, %0d passed, %0d failed",
                   n_tests, n_tests - n_fail, n_fail);
          done_o <= 1'b1;
        end
      end
    end
    err_cnt_o <= n_fail;
  end

endmodule

`default_nettype wire

/* hw/byp_ctrl_top.sv */
/*
 * Operand bypass and hazard control top level
 * Maps the flat pipeline status ports onto the stage bundles
 */

`timescale 1ns/1ps
`default_nettype none

`include "byp_macros.svh"

module byp_ctrl_top (
  // Instruction in ID
  input  wire logic [`BYP_NUM_RPORTS-1:0] rf_re_id_i,
  input  byp_pkg::rf_addr_t               rf_raddr_a_id_i,
  input  byp_pkg::rf_addr_t               rf_raddr_b_id_i,
  input  wire logic                       id_valid_i,
  input  wire logic                       jalr_id_i,
  input  wire logic                       csr_id_i,
  input  wire logic                       mret_id_i,
  input  wire logic                       wfi_id_i,
  input  wire logic                       fetch_err_id_i,
  input  wire logic                       trigger_id_i,

  // EX stage status
  input  wire logic                       ex_valid_i,
  input  wire logic                       ex_rf_we_i,
  input  byp_pkg::rf_addr_t               ex_rf_waddr_i,
  input  wire logic                       ex_lsu_en_i,
  input  wire logic                       ex_csr_en_i,
  input  wire logic                       ex_mret_i,
  input  wire logic                       ex_wfi_i,

  // WB stage status
  input  wire logic                       wb_valid_i,
  input  wire logic                       wb_rf_we_i,
  input  byp_pkg::rf_addr_t               wb_rf_waddr_i,
  input  wire logic                       wb_lsu_en_i,
  input  wire logic                       wb_csr_en_i,
  input  wire logic                       wb_mret_i,
  input  wire logic                       wb_ready_i,

  // Forwarding selects and stalls
  output byp_pkg::fw_sel_e                op_a_sel_o,
  output byp_pkg::fw_sel_e                op_b_sel_o,
  output byp_pkg::jalr_sel_e              jalr_sel_o,
  output logic                            load_stall_o,
  output logic                            jalr_stall_o,
  output logic                            csr_stall_o,
  output logic                            wfi_stall_o,
  output logic                            deassert_we_o
);

  // Read addresses indexed by port, A on port 0 and B on port 1
  byp_pkg::rf_addr_t rf_raddr_id [`BYP_NUM_RPORTS];

  byp_stage_if ex_if ();
  byp_stage_if wb_if ();
  byp_match_if match_if ();

  assign rf_raddr_id[0] = rf_raddr_a_id_i;
  assign rf_raddr_id[1] = rf_raddr_b_id_i;

  assign ex_if.instr_valid = ex_valid_i;
  assign ex_if.rf_we       = ex_rf_we_i;
  assign ex_if.rf_waddr    = ex_rf_waddr_i;
  assign ex_if.lsu_en      = ex_lsu_en_i;
  assign ex_if.csr_en      = ex_csr_en_i;
  assign ex_if.mret        = ex_mret_i;

  assign wb_if.instr_valid = wb_valid_i;
  assign wb_if.rf_we       = wb_rf_we_i;
  assign wb_if.rf_waddr    = wb_rf_waddr_i;
  assign wb_if.lsu_en      = wb_lsu_en_i;
  assign wb_if.csr_en      = wb_csr_en_i;
  assign wb_if.mret        = wb_mret_i;

  // Hit detection is shared by forwarding and stall logic
  byp_reg_match u_reg_match (
    .rf_re_id_i    (rf_re_id_i),
    .rf_raddr_id_i (rf_raddr_id),
    .ex_i          (ex_if),
    .wb_i          (wb_if),
    .hit_o         (match_if)
  );

  byp_fwd_ctrl u_fwd_ctrl (
    .hit_i      (match_if),
    .op_a_sel_o (op_a_sel_o),
    .jalr_sel_o (jalr_sel_o),
    .op_b_sel_o (op_b_sel_o)
  );

  byp_stall_ctrl u_stall_ctrl (
    .hit_i          (match_if),
    .ex_i           (ex_if),
    .wb_i           (wb_if),
    .id_valid_i     (id_valid_i),
    .jalr_id_i      (jalr_id_i),
    .csr_id_i       (csr_id_i),
    .mret_id_i      (mret_id_i),
    .wfi_id_i       (wfi_id_i),
    .fetch_err_id_i (fetch_err_id_i),
    .trigger_id_i   (trigger_id_i),
    .ex_wfi_i       (ex_wfi_i),
    .wb_ready_i     (wb_ready_i),
    .load_stall_o   (load_stall_o),
    .jalr_stall_o   (jalr_stall_o),
    .csr_stall_o    (csr_stall_o),
    .wfi_stall_o    (wfi_stall_o),
    .deassert_we_o  (deassert_we_o)
  );

endmodule

`default_nettype wire

/* hw/byp_stall_ctrl.sv */
/*
 * Stall control
 * Raises load-use, JALR, CSR and WFI stalls and the ID write-enable kill
 */

`timescale 1ns/1ps
`default_nettype none

module byp_stall_ctrl (
  byp_match_if.dst  hit_i,
  byp_stage_if.dst  ex_i,
  byp_stage_if.dst  wb_i,

  // Instruction in ID
  input  wire logic id_valid_i,
  input  wire logic jalr_id_i,
  input  wire logic csr_id_i,
  input  wire logic mret_id_i,
  input  wire logic wfi_id_i,
  input  wire logic fetch_err_id_i,
  input  wire logic trigger_id_i,

  // Later stages
  input  wire logic ex_wfi_i,
  input  wire logic wb_ready_i,

  output logic      load_stall_o,
  output logic      jalr_stall_o,
  output logic      csr_stall_o,
  output logic      wfi_stall_o,
  output logic      deassert_we_o
);

  // ID instruction reads CSR state, directly or implicitly
  // WFI counts here because it reads mstatus.tw and the privilege level
  logic csr_read_id;
  // Some CSR is being written further down the pipe
  // mret counts as a write since it updates mstatus
  logic csr_write_ex_wb;

  assign csr_read_id     = id_valid_i && (csr_id_i || mret_id_i || wfi_id_i);
  assign csr_write_ex_wb = (ex_i.instr_valid && (ex_i.csr_en || ex_i.mret)) ||
                           (wb_i.instr_valid && (wb_i.csr_en || wb_i.mret));

  ////////////////////////////////////////////////////////////////////////////
  // Data hazards
  ////////////////////////////////////////////////////////////////////////////

  // A load in EX has no data yet, so any consumer in ID has to wait
  // A WB writer is forwardable unless WB itself is still waiting on the bus
  assign load_stall_o = (ex_i.lsu_en && (|hit_i.ex_hit)) ||
                        (!wb_ready_i && (|hit_i.wb_hit));

  // The jump target path only takes ALU results from WB
  // An EX writer or a load in WB holds the JALR in ID
  assign jalr_stall_o = id_valid_i && jalr_id_i &&
                        (hit_i.ex_jalr_hit || (hit_i.wb_jalr_hit && wb_i.lsu_en));

  ////////////////////////////////////////////////////////////////////////////
  // Control hazards
  ////////////////////////////////////////////////////////////////////////////

  // CSR state is not forwarded, so readers wait until EX and WB drain
  assign csr_stall_o = csr_read_id && csr_write_ex_wb;

  // Hold ID while a WFI sits in EX so nothing follows it into memory
  assign wfi_stall_o = ex_wfi_i && ex_i.instr_valid;

  // The ID instruction becomes a nop on a fetch fault or a debug trigger
  // It still travels to WB where the exception or debug entry is taken
  assign deassert_we_o = fetch_err_id_i || trigger_id_i;

endmodule

`default_nettype wire

/* hw/byp_fwd_ctrl.sv */
/*
 * Forwarding control
 * Picks the operand A, operand B and jump target sources for ID
 */

`timescale 1ns/1ps
`default_nettype none

module byp_fwd_ctrl (
  byp_match_if.dst           hit_i,
  output byp_pkg::fw_sel_e   op_a_sel_o,
  output byp_pkg::jalr_sel_e jalr_sel_o,
  output byp_pkg::fw_sel_e   op_b_sel_o
);

  ////////////////////////////////////////////////////////////////////////////
  // Operand forwarding
  ////////////////////////////////////////////////////////////////////////////

  // Source for one read port given its EX and WB hits
  // EX holds the younger result, so it wins when both stages write the register
  function automatic byp_pkg::fw_sel_e pick_src(input logic ex_hit, input logic wb_hit);
    byp_pkg::fw_sel_e sel;
    sel = byp_pkg::SEL_REGFILE;
    if (wb_hit) begin
      sel = byp_pkg::SEL_FW_WB;
    end
    if (ex_hit) begin
      sel = byp_pkg::SEL_FW_EX;
    end
    return sel;
  endfunction

  always_comb begin
    // Port 0 is rs1 and feeds operand A
    op_a_sel_o = pick_src(hit_i.ex_hit[0], hit_i.wb_hit[0]);
    // Port 1 is rs2 and feeds operand B
    op_b_sel_o = pick_src(hit_i.ex_hit[1], hit_i.wb_hit[1]);
  end

  ////////////////////////////////////////////////////////////////////////////
  // Jump register target
  ////////////////////////////////////////////////////////////////////////////

  // Only a WB result reaches the jump target path
  // An EX writer or a load in WB is covered by the JALR stall instead
  always_comb begin
    jalr_sel_o = byp_pkg::SELJ_REGFILE;
    if (hit_i.wb_jalr_hit) begin
      jalr_sel_o = byp_pkg::SELJ_FW_WB;
    end
  end

endmodule

`default_nettype wire

/* hw/byp_reg_match.sv */
/*
 * Register match unit
 * Compares the ID read addresses against the EX and WB write addresses
 */

`timescale 1ns/1ps
`default_nettype none

`include "byp_macros.svh"

module byp_reg_match (
  input  wire logic [`BYP_NUM_RPORTS-1:0] rf_re_id_i,
  input  byp_pkg::rf_addr_t               rf_raddr_id_i [`BYP_NUM_RPORTS],
  byp_stage_if.dst                        ex_i,
  byp_stage_if.dst                        wb_i,
  byp_match_if.src                        hit_o
);

  // A stage only counts as a writer with a valid instruction that has rf_we set
  logic                       ex_writes;
  logic                       wb_writes;
  logic [`BYP_NUM_RPORTS-1:0] ex_port_hit;
  logic [`BYP_NUM_RPORTS-1:0] wb_port_hit;

  assign ex_writes = ex_i.instr_valid && ex_i.rf_we;
  assign wb_writes = wb_i.instr_valid && wb_i.rf_we;

  // x0 reads as zero so it is excluded from every match
  for (genvar i = 0; i < `BYP_NUM_RPORTS; i++) begin : gen_port_hit
    assign ex_port_hit[i] = ex_writes && (ex_i.rf_waddr == rf_raddr_id_i[i]) &&
                            (|rf_raddr_id_i[i]) && rf_re_id_i[i];
    assign wb_port_hit[i] = wb_writes && (wb_i.rf_waddr == rf_raddr_id_i[i]) &&
                            (|rf_raddr_id_i[i]) && rf_re_id_i[i];
  end

  assign hit_o.ex_hit = ex_port_hit;
  assign hit_o.wb_hit = wb_port_hit;

  // JALR always reads rs1 on port 0, so its read enable is implied
  assign hit_o.ex_jalr_hit = ex_writes && (ex_i.rf_waddr == rf_raddr_id_i[0]) &&
                             (|rf_raddr_id_i[0]);
  assign hit_o.wb_jalr_hit = wb_writes && (wb_i.rf_waddr == rf_raddr_id_i[0]) &&
                             (|rf_raddr_id_i[0]);

endmodule

`default_nettype wire

/* hw/byp_match_if.sv */
/*
 * Register hit bundle
 * Qualified ID read versus EX and WB write matches
 */

`timescale 1ns/1ps
`default_nettype none

`include "byp_macros.svh"

interface byp_match_if;

  // One bit per ID read port, set when that stage will write the register
  logic [`BYP_NUM_RPORTS-1:0] ex_hit;
  logic [`BYP_NUM_RPORTS-1:0] wb_hit;

  // Port 0 hits for the jump register path, read enable not required
  logic                       ex_jalr_hit;
  logic                       wb_jalr_hit;

  modport src (
    output ex_hit, wb_hit, ex_jalr_hit, wb_jalr_hit
  );

  modport dst (
    input ex_hit, wb_hit, ex_jalr_hit, wb_jalr_hit
  );

endinterface

`default_nettype wire

/* hw/byp_stage_if.sv */
/*
 * Pipeline stage status bundle
 * Carries the write-back and instruction class view of EX or WB
 */

`timescale 1ns/1ps
`default_nettype none

interface byp_stage_if;

  // Stage holds a real instruction
  logic                instr_valid;
  // Instruction writes the register file
  logic                rf_we;
  // Destination register of that write
  byp_pkg::rf_addr_t   rf_waddr;
  // Load or store in this stage
  logic                lsu_en;
  // Explicit CSR access in this stage
  logic                csr_en;
  // mret in this stage which implicitly writes mstatus
  logic                mret;

  // Side that fills in the stage status
  modport src (
    output instr_valid, rf_we, rf_waddr, lsu_en, csr_en, mret
  );

  // Side of the hazard logic that inspects the stage
  modport dst (
    input instr_valid, rf_we, rf_waddr, lsu_en, csr_en, mret
  );

endinterface

`default_nettype wire

/* hw/byp_pkg.sv */
/*
 * Operand bypass and hazard control
 * Shared types for register indices and forwarding mux selects
 */

`default_nettype none

`include "byp_macros.svh"

package byp_pkg;

  // Register file index as seen on read and write ports
  typedef logic [`BYP_RF_ADDR_W-1:0] rf_addr_t;

  // Source select for the ALU operand forwarding muxes in ID
  // The encoding leaves 2'b11 free for a further source
  typedef enum logic [1:0] {
    SEL_REGFILE = 2'b00,
    SEL_FW_EX   = 2'b01,
    SEL_FW_WB   = 2'b10
  } fw_sel_e;

  // Source select for the jump register target path
  // Only WB can forward here since the EX result arrives too late
  typedef enum logic {
    SELJ_REGFILE = 1'b0,
    SELJ_FW_WB   = 1'b1
  } jalr_sel_e;

endpackage

`default_nettype wire

/* hw/byp_macros.svh */
/*
 * Operand bypass and hazard control
 * Width and count constants shared by the package, interfaces and RTL
 */

`ifndef BYP_MACROS_SVH
`define BYP_MACROS_SVH

// Register file index width for a 32 entry integer register file
`define BYP_RF_ADDR_W 5

// Number of register file read ports used by the instruction in ID
// Port 0 feeds operand A and the JALR target, port 1 feeds operand B
`define BYP_NUM_RPORTS 2

`endif
